//--- sources.f
+incdir+include
verilog/rvseed_pkg.sv
verilog/ctrl.sv
verilog/imm_gen.sv
verilog/alu.sv
verilog/regfile.sv
verilog/rvseed_core.sv
verification/rvseed_assert.sv
verification/rvseed_tb.sv

//--- Bender.yml
package:
  name: rvseed

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/rvseed_pkg.sv
      - verilog/ctrl.sv
      - verilog/imm_gen.sv
      - verilog/alu.sv
      - verilog/regfile.sv
      - verilog/rvseed_core.sv
      - target: test
        files:
          - verification/rvseed_assert.sv
          - verification/rvseed_tb.sv

//--- verification/rvseed_tb.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module rvseed_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int PROG_WORDS   = 64;
    localparam int TEST_RUNS    = 8;
    localparam int INST_TOTAL   = 90;                  // worst case over all runs
    localparam int RUN_OVERHEAD = RESET_CYCLES + 8;    // reset, start and drain
    localparam int WATCHDOG_NS  = 2 * (INST_TOTAL + TEST_RUNS * RUN_OVERHEAD) * CLK_PERIOD;

    logic                   clk;
    logic                   reset;
    logic [`CPU_WIDTH-1:0]  imem_addr;
    logic [`INST_WIDTH-1:0] imem_data;
    logic                   dmem_wen;
    logic [`CPU_WIDTH-1:0]  dmem_addr;
    logic [`CPU_WIDTH-1:0]  dmem_wdata;
    logic                   halted;
    logic                   illegal;

    logic [`INST_WIDTH-1:0] prog [PROG_WORDS];
    int                     fill_idx;
    logic [31:0]            lcg_state;
    logic [63:0]            store_addr [$];
    logic [63:0]            store_data [$];
    logic [63:0]            exp_addr [$];
    logic [63:0]            exp_data [$];

    rvseed_core dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .halted     (halted),
        .illegal    (illegal)
    );

    bind rvseed_core rvseed_assert u_assert (
        .clk       (clk),
        .reset     (reset),
        .halted    (halted),
        .dmem_wen  (dmem_wen),
        .imem_addr (imem_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fetch past the program reads a zero word
    assign imem_data = (imem_addr < 64'(4 * PROG_WORDS)) ? prog[imem_addr[7:2]] : '0;

    always @(posedge clk) begin
        if (dmem_wen) begin
            store_addr.push_back(dmem_addr);
            store_data.push_back(dmem_wdata);
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, `INST_SD, imm[4:0], `INST_TYPE_S};
    endfunction

    function automatic logic [31:0] b_type(input int off, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {off[12], off[10:5], rs2, rs1, `INST_BNE, off[4:1], off[11], `INST_TYPE_B};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input int off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `INST_JAL};
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [63:0] upper_imm(input logic [19:0] v);
        return {{32{v[19]}}, v, 12'b0};
    endfunction

    task automatic new_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = {25'(i), 7'b0000000}; // opcode 0, decodes as illegal
        end
        fill_idx = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(input logic [31:0] word);
        prog[fill_idx] = word;
        fill_idx++;
    endtask

    task automatic expect_store(input logic [63:0] addr, input logic [63:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", what, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_stores(input string name);
        check_value({name, " store count"}, exp_addr.size(), store_addr.size());
        foreach (exp_addr[i]) begin
            check_value($sformatf("%s store %0d addr", name, i), exp_addr[i], store_addr[i]);
            check_value($sformatf("%s store %0d data", name, i), exp_data[i], store_data[i]);
        end
    endtask

    task automatic run_program(input string name, input logic expect_illegal);
        store_addr.delete();
        store_data.delete();
        @(posedge clk);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (!halted) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // any late store lands here
        check_value({name, " halted"}, 64'd1, {63'd0, halted});
        check_value({name, " illegal"}, {63'd0, expect_illegal}, {63'd0, illegal});
        compare_stores(name);
    endtask

    task automatic arith_test(input int round);
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] r;
        logic [19:0] hi1;
        logic [19:0] hi2;
        logic [63:0] a;
        logic [63:0] b;
        v1 = next_random();
        v2 = next_random();
        r = next_random();
        hi1 = 20'((v1 + 32'h800) >> 12); // round up when addi subtracts
        hi2 = 20'((v2 + 32'h800) >> 12);
        a = upper_imm(hi1) + sext12(v1[11:0]);
        b = upper_imm(hi2) + sext12(v2[11:0]);
        new_program();
        emit(u_type(hi1, 1, `INST_LUI));
        emit(i_type(v1[11:0], 1, `INST_ADDI, 1, `INST_TYPE_I));
        emit(u_type(hi2, 2, `INST_LUI));
        emit(i_type(v2[11:0], 2, `INST_ADDI, 2, `INST_TYPE_I));
        emit(r_type(7'b0, 2, 1, `INST_ADD_SUB, 3, `INST_TYPE_R));
        emit(r_type(`FUNCT7_SUB, 2, 1, `INST_ADD_SUB, 4, `INST_TYPE_R));
        emit(i_type(r[11:0], 1, `INST_ADDI, 5, `INST_TYPE_I));
        emit(r_type(`FUNCT7_SUB, 1, 2, `INST_ADD_SUB, 6, `INST_TYPE_R));
        emit(s_type('h100, 3, 0));
        emit(s_type('h108, 4, 0));
        emit(s_type('h110, 5, 0));
        emit(s_type('h118, 6, 0));
        emit(`INST_EBREAK);
        expect_store(64'h100, a + b);
        expect_store(64'h108, a - b);
        expect_store(64'h110, a + sext12(r[11:0]));
        expect_store(64'h118, b - a);
        run_program($sformatf("arith round %0d", round), 1'b0);
    endtask

    task automatic upper_test();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [19:0] hi2;
        r1 = next_random();
        r2 = next_random();
        hi2 = r2[19:0] | 20'h80000; // negative upper immediate
        new_program();
        emit(u_type(r1[19:0], 1, `INST_LUI));
        emit(u_type(hi2, 2, `INST_AUIPC)); // at pc 4
        emit(s_type('h100, 1, 0));
        emit(s_type('h108, 2, 0));
        emit(`INST_EBREAK);
        expect_store(64'h100, upper_imm(r1[19:0]));
        expect_store(64'h108, 64'd4 + upper_imm(hi2));
        run_program("lui auipc", 1'b0);
    endtask

    task automatic bne_test();
        logic [31:0] r;
        int          count;
        r = next_random();
        count = 1 + int'(r % 32'd6);
        new_program();
        emit(i_type(5, 0, `INST_ADDI, 1, `INST_TYPE_I));
        emit(i_type(5, 0, `INST_ADDI, 2, `INST_TYPE_I));
        emit(b_type(8, 2, 1));             // equal, falls through
        emit(s_type('h100, 1, 0));
        emit(i_type(7, 0, `INST_ADDI, 2, `INST_TYPE_I));
        emit(b_type(8, 2, 1));             // unequal, taken
        emit(s_type('h108, 1, 0));         // skipped
        emit(i_type(count, 0, `INST_ADDI, 3, `INST_TYPE_I));
        emit(i_type(0, 0, `INST_ADDI, 4, `INST_TYPE_I));
        emit(i_type(10, 4, `INST_ADDI, 4, `INST_TYPE_I));
        emit(i_type(-1, 3, `INST_ADDI, 3, `INST_TYPE_I));
        emit(b_type(-8, 0, 3));            // loop back until x3 is zero
        emit(s_type('h110, 4, 0));
        emit(s_type('h118, 3, 0));
        emit(`INST_EBREAK);
        expect_store(64'h100, 64'd5);
        expect_store(64'h110, 64'(10 * count));
        expect_store(64'h118, 64'd0);
        run_program("bne", 1'b0);
    endtask

    task automatic jump_test();
        new_program();
        emit(j_type(8, 1));                // jal to 8, link 4
        emit(s_type('h200, 1, 0));
        emit(i_type(28, 0, `INST_ADDI, 5, `INST_TYPE_I));
        emit(i_type(1, 5, `INST_JALR_F3, 2, `INST_JALR)); // target 29 with bit 0 cleared
        emit(s_type('h208, 1, 0));
        emit(s_type('h210, 1, 0));
        emit(s_type('h218, 1, 0));
        emit(s_type('h100, 1, 0));
        emit(s_type('h108, 2, 0));
        emit(`INST_EBREAK);
        expect_store(64'h100, 64'd4);
        expect_store(64'h108, 64'd16);
        run_program("jal jalr", 1'b0);
    endtask

    task automatic x0_halt_test();
        new_program();
        emit(i_type(123, 0, `INST_ADDI, 0, `INST_TYPE_I));
        emit(u_type(20'h12345, 0, `INST_LUI));
        emit(s_type('h100, 0, 0));
        emit(i_type(9, 0, `INST_ADDI, 1, `INST_TYPE_I));
        emit(s_type('h108, 1, 0));
        emit(`INST_EBREAK);
        emit(s_type('h110, 1, 0));         // never reached
        emit(s_type('h118, 1, 0));
        expect_store(64'h100, 64'd0);
        expect_store(64'h108, 64'd9);
        run_program("x0 ebreak", 1'b0);
    endtask

    task automatic illegal_test();
        new_program();
        emit(i_type(42, 0, `INST_ADDI, 1, `INST_TYPE_I));
        emit(s_type('h100, 1, 0));
        emit({7'b0, 5'd1, 5'd0, 3'b010, 5'b10000, `INST_TYPE_S}); // sw, not supported
        emit(s_type('h108, 1, 0));
        emit(`INST_EBREAK);
        expect_store(64'h100, 64'd42);
        run_program("illegal", 1'b1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the core did not halt in time", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        lcg_state = 32'hadf8;
        new_program();
        for (int i = 0; i < 3; i++) begin
            arith_test(i);
        end
        upper_test();
        bne_test();
        jump_test();
        x0_halt_test();
        illegal_test();
        if (dut.u_assert.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("%0d concurrent assertion failures during the run",
                     dut.u_assert.fail_count);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

endmodule

//--- verification/rvseed_assert.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module rvseed_assert (
    input logic                  clk,
    input logic                  reset,
    input logic                  halted,
    input logic                  dmem_wen,
    input logic [`CPU_WIDTH-1:0] imem_addr
);

    int fail_count = 0; // failed assertions so far

    // sticky until the next reset
    halt_sticky: assert property (
        @(posedge clk) disable iff (reset) halted |=> halted
    ) else begin
        fail_count++;
        $error("halted fell without a reset");
    end

    halt_no_store: assert property (
        @(posedge clk) disable iff (reset) halted |-> !dmem_wen
    ) else begin
        fail_count++;
        $error("store issued while halted");
    end

    halt_pc_hold: assert property (
        @(posedge clk) disable iff (reset) halted |=> $stable(imem_addr)
    ) else begin
        fail_count++;
        $error("fetch address moved while halted");
    end

    // word aligned fetch
    pc_aligned: assert property (
        @(posedge clk) disable iff (reset) !halted |-> (imem_addr[1:0] == 2'b00)
    ) else begin
        fail_count++;
        $error("fetch address not 4-byte aligned");
    end

endmodule

//--- verilog/rvseed_core.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module rvseed_core (
    input  logic                   clk,
    input  logic                   reset,
    output logic [`CPU_WIDTH-1:0]  imem_addr,
    input  logic [`INST_WIDTH-1:0] imem_data,
    output logic                   dmem_wen,
    output logic [`CPU_WIDTH-1:0]  dmem_addr,
    output logic [`CPU_WIDTH-1:0]  dmem_wdata,
    output logic                   halted,
    output logic                   illegal
);
    import rvseed_pkg::*;

    logic [`CPU_WIDTH-1:0]      pc;
    logic [`CPU_WIDTH-1:0]      pc_next;
    logic [`CPU_WIDTH-1:0]      pc_imm;      // branch and jal target
    logic [`CPU_WIDTH-1:0]      jalr_target;
    logic [`CPU_WIDTH-1:0]      imm;
    logic [`CPU_WIDTH-1:0]      alu_result;
    logic                       alu_zero;
    logic [`CPU_WIDTH-1:0]      reg1_rdata;
    logic [`CPU_WIDTH-1:0]      reg2_rdata;
    logic [`REG_ADDR_WIDTH-1:0] reg1_raddr;
    logic [`REG_ADDR_WIDTH-1:0] reg2_raddr;
    logic [`REG_ADDR_WIDTH-1:0] reg_waddr;
    ctrl_sig_t                  sig;
    logic                       started;     // one idle cycle after reset
    logic                       commit;

    ctrl u_ctrl (
        .inst       (imem_data),
        .reg1_raddr (reg1_raddr),
        .reg2_raddr (reg2_raddr),
        .reg_waddr  (reg_waddr),
        .sig        (sig)
    );

    imm_gen u_imm_gen (
        .inst       (imem_data),
        .imm_gen_op (sig.imm_gen_op),
        .imm        (imm)
    );

    alu u_alu (
        .alu_op      (sig.alu_op),
        .alu_src_sel (sig.alu_src_sel),
        .pc          (pc),
        .reg1_rdata  (reg1_rdata),
        .reg2_rdata  (reg2_rdata),
        .imm         (imm),
        .result      (alu_result),
        .zero        (alu_zero)
    );

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .wen    (sig.reg_wen & commit),
        .waddr  (reg_waddr),
        .raddr1 (reg1_raddr),
        .raddr2 (reg2_raddr),
        .wdata  (alu_result),
        .rdata1 (reg1_rdata),
        .rdata2 (reg2_rdata)
    );

    // ebreak and unknown encodings retire without effect
    assign commit = started & ~halted & ~sig.halt & ~sig.illegal;

    assign pc_imm      = pc + imm;
    assign jalr_target = (reg1_rdata + imm) & ~`CPU_WIDTH'd1;

    always_comb begin
        pc_next = pc + `CPU_WIDTH'd4;
        if (sig.jump && sig.jalr) begin
            pc_next = jalr_target;
        end else if (sig.jump || (sig.branch && !alu_zero)) begin
            pc_next = pc_imm; // jal, or bne taken
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `RESET_PC;
            started <= 1'b0;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else begin
            started <= 1'b1;
            if (commit) begin
                pc <= pc_next;
            end
            if (started && !halted && (sig.halt || sig.illegal)) begin
                halted  <= 1'b1;        // sticky until reset
                illegal <= sig.illegal;
            end
        end
    end

    assign imem_addr  = pc;
    assign dmem_wen   = sig.mem_wen & commit;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = reg2_rdata;

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module regfile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wen,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2,
    input  logic [`CPU_WIDTH-1:0]      wdata,
    output logic [`CPU_WIDTH-1:0]      rdata1,
    output logic [`CPU_WIDTH-1:0]      rdata2
);

    localparam int NUM_REGS = 1 << `REG_ADDR_WIDTH;

    logic [`CPU_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module alu (
    input  rvseed_pkg::alu_op_e   alu_op,
    input  rvseed_pkg::alu_src_e  alu_src_sel,
    input  logic [`CPU_WIDTH-1:0] pc,
    input  logic [`CPU_WIDTH-1:0] reg1_rdata,
    input  logic [`CPU_WIDTH-1:0] reg2_rdata,
    input  logic [`CPU_WIDTH-1:0] imm,
    output logic [`CPU_WIDTH-1:0] result,
    output logic                  zero
);
    import rvseed_pkg::*;

    logic [`CPU_WIDTH-1:0] op_a;
    logic [`CPU_WIDTH-1:0] op_b;

    always_comb begin
        case (alu_src_sel)
            ALU_SRC_REG: begin
                op_a = reg1_rdata;
                op_b = reg2_rdata;
            end
            ALU_SRC_IMM: begin
                op_a = reg1_rdata;
                op_b = imm;
            end
            ALU_SRC_IMM_PC: begin
                op_a = pc;
                op_b = imm;
            end
            default: begin
                op_a = pc;
                op_b = `CPU_WIDTH'd4;
            end
        endcase
    end

    // wraps at 64 bits
    assign result = (alu_op == ALU_SUB) ? op_a - op_b : op_a + op_b;
    assign zero   = (result == '0);

endmodule

//--- verilog/imm_gen.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module imm_gen (
    input  logic [`INST_WIDTH-1:0]  inst,
    input  rvseed_pkg::imm_gen_op_e imm_gen_op,
    output logic [`CPU_WIDTH-1:0]   imm
);
    import rvseed_pkg::*;

    logic sign;

    assign sign = inst[`INST_WIDTH-1];

    always_comb begin
        case (imm_gen_op)
            IMM_GEN_I: begin
                imm = {{(`CPU_WIDTH-12){sign}}, inst[31:20]};
            end
            IMM_GEN_S: begin
                imm = {{(`CPU_WIDTH-12){sign}}, inst[31:25], inst[11:7]};
            end
            IMM_GEN_B: begin
                imm = {{(`CPU_WIDTH-13){sign}}, inst[31], inst[7],
                       inst[30:25], inst[11:8], 1'b0};
            end
            IMM_GEN_U: begin
                imm = {{(`CPU_WIDTH-32){sign}}, inst[31:12], 12'b0};
            end
            IMM_GEN_J: begin
                imm = {{(`CPU_WIDTH-21){sign}}, inst[31], inst[19:12],
                       inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0; // unused encodings
            end
        endcase
    end

endmodule

//--- verilog/ctrl.sv
`timescale 1ns/1ps
`include "rvseed_defines.svh"

module ctrl (
    input  logic [`INST_WIDTH-1:0]     inst,
    output logic [`REG_ADDR_WIDTH-1:0] reg1_raddr,
    output logic [`REG_ADDR_WIDTH-1:0] reg2_raddr,
    output logic [`REG_ADDR_WIDTH-1:0] reg_waddr,
    output rvseed_pkg::ctrl_sig_t      sig
);
    import rvseed_pkg::*;

    logic [`OPCODE_WIDTH-1:0]   opcode;
    logic [`FUNCT3_WIDTH-1:0]   funct3;
    logic [`FUNCT7_WIDTH-1:0]   funct7;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;

    assign opcode = inst[`OPCODE_WIDTH-1:0];
    assign funct3 = inst[`FUNCT3_BASE+`FUNCT3_WIDTH-1:`FUNCT3_BASE];
    assign funct7 = inst[`FUNCT7_BASE+`FUNCT7_WIDTH-1:`FUNCT7_BASE];
    assign rd     = inst[`RD_BASE+`REG_ADDR_WIDTH-1:`RD_BASE];
    assign rs1    = inst[`RS1_BASE+`REG_ADDR_WIDTH-1:`RS1_BASE];
    assign rs2    = inst[`RS2_BASE+`REG_ADDR_WIDTH-1:`RS2_BASE];

    always_comb begin
        sig             = '0;
        sig.imm_gen_op  = IMM_GEN_I;
        sig.alu_op      = ALU_ADD;
        sig.alu_src_sel = ALU_SRC_REG;
        reg1_raddr      = '0;
        reg2_raddr      = '0;
        reg_waddr       = '0;

        case (opcode)
            `INST_TYPE_R: begin
                sig.reg_wen = 1'b1;
                reg1_raddr  = rs1;
                reg2_raddr  = rs2;
                reg_waddr   = rd;
                if (funct3 != `INST_ADD_SUB) begin
                    sig.illegal = 1'b1;
                end else if (funct7 == `FUNCT7_SUB) begin
                    sig.alu_op = ALU_SUB;
                end else if (funct7 != '0) begin
                    sig.illegal = 1'b1;
                end
            end
            `INST_TYPE_I: begin
                sig.reg_wen     = 1'b1;
                sig.alu_src_sel = ALU_SRC_IMM;
                reg1_raddr      = rs1;
                reg_waddr       = rd;
                sig.illegal     = (funct3 != `INST_ADDI);
            end
            `INST_TYPE_B: begin
                sig.branch     = 1'b1;
                sig.imm_gen_op = IMM_GEN_B;
                sig.alu_op     = ALU_SUB;   // zero flag gives equality
                reg1_raddr     = rs1;
                reg2_raddr     = rs2;
                sig.illegal    = (funct3 != `INST_BNE);
            end
            `INST_TYPE_S: begin
                sig.mem_wen     = 1'b1;
                sig.imm_gen_op  = IMM_GEN_S;
                sig.alu_src_sel = ALU_SRC_IMM; // address rs1 + imm
                reg1_raddr      = rs1;
                reg2_raddr      = rs2;         // store data
                sig.illegal     = (funct3 != `INST_SD);
            end
            `INST_JAL: begin
                sig.jump        = 1'b1;
                sig.reg_wen     = 1'b1;
                sig.imm_gen_op  = IMM_GEN_J;
                sig.alu_src_sel = ALU_SRC_FOUR_PC; // link value
                reg_waddr       = rd;
            end
            `INST_JALR: begin
                sig.jump        = 1'b1;
                sig.jalr        = 1'b1;
                sig.reg_wen     = 1'b1;
                sig.alu_src_sel = ALU_SRC_FOUR_PC;
                reg1_raddr      = rs1;             // target base
                reg_waddr       = rd;
                sig.illegal     = (funct3 != `INST_JALR_F3);
            end
            `INST_LUI: begin
                sig.reg_wen     = 1'b1;
                sig.imm_gen_op  = IMM_GEN_U;
                sig.alu_src_sel = ALU_SRC_IMM;     // x0 + imm
                reg_waddr       = rd;
            end
            `INST_AUIPC: begin
                sig.reg_wen     = 1'b1;
                sig.imm_gen_op  = IMM_GEN_U;
                sig.alu_src_sel = ALU_SRC_IMM_PC;
                reg_waddr       = rd;
            end
            `INST_SYSTEM: begin
                if (inst == `INST_EBREAK) begin
                    sig.halt = 1'b1;
                end else begin
                    sig.illegal = 1'b1;
                end
            end
            default: begin
                sig.illegal = 1'b1;
            end
        endcase

        // an unknown encoding must not change any state
        if (sig.illegal) begin
            sig.branch  = 1'b0;
            sig.jump    = 1'b0;
            sig.jalr    = 1'b0;
            sig.reg_wen = 1'b0;
            sig.mem_wen = 1'b0;
        end
    end

endmodule

//--- verilog/rvseed_pkg.sv
package rvseed_pkg;

    // immediate format for imm_gen
    typedef enum logic [2:0] {
        IMM_GEN_I = 3'd0,
        IMM_GEN_S = 3'd1,
        IMM_GEN_B = 3'd2,
        IMM_GEN_U = 3'd3,
        IMM_GEN_J = 3'd4
    } imm_gen_op_e;

    typedef enum logic [0:0] {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_e;

    // operand pair fed to the alu
    typedef enum logic [1:0] {
        ALU_SRC_REG     = 2'd0, // rs1, rs2
        ALU_SRC_IMM     = 2'd1, // rs1, imm
        ALU_SRC_IMM_PC  = 2'd2, // pc, imm
        ALU_SRC_FOUR_PC = 2'd3  // pc, 4
    } alu_src_e;

    // decoded control for one instruction
    typedef struct packed {
        logic        branch;      // conditional branch (bne)
        logic        jump;        // jal or jalr
        logic        jalr;        // target from rs1
        logic        reg_wen;
        logic        mem_wen;
        imm_gen_op_e imm_gen_op;
        alu_op_e     alu_op;
        alu_src_e    alu_src_sel;
        logic        halt;        // ebreak
        logic        illegal;     // unknown encoding
    } ctrl_sig_t;

endpackage

//--- include/rvseed_defines.svh
`ifndef RVSEED_DEFINES_SVH
`define RVSEED_DEFINES_SVH

// datapath widths
`define CPU_WIDTH         64
`define INST_WIDTH        32
`define REG_ADDR_WIDTH    5

// instruction field widths
`define OPCODE_WIDTH      7
`define FUNCT3_WIDTH      3
`define FUNCT7_WIDTH      7

// instruction field positions
`define RD_BASE           7
`define FUNCT3_BASE       12
`define RS1_BASE          15
`define RS2_BASE          20
`define FUNCT7_BASE       25

// major opcodes
`define INST_TYPE_R       7'b0110011     // add, sub
`define INST_TYPE_I       7'b0010011     // addi
`define INST_TYPE_B       7'b1100011     // bne
`define INST_TYPE_S       7'b0100011     // sd
`define INST_JAL          7'b1101111
`define INST_JALR         7'b1100111
`define INST_LUI          7'b0110111
`define INST_AUIPC        7'b0010111
`define INST_SYSTEM       7'b1110011     // only ebreak accepted

// funct3 values
`define INST_ADD_SUB      3'b000
`define INST_ADDI         3'b000
`define INST_BNE          3'b001
`define INST_SD           3'b011
`define INST_JALR_F3      3'b000

// funct7 value for sub, add uses all zeros
`define FUNCT7_SUB        7'b0100000

// full ebreak word
`define INST_EBREAK       32'h0010_0073

// first fetch address
`define RESET_PC          64'h0000_0000_0000_0000

`endif
